// File: include/frame_parser_settings.svh
`ifndef FRAME_PARSER_SETTINGS_SVH
`define FRAME_PARSER_SETTINGS_SVH

// Host-to-device start of frame
`define FP_SOF_BYTE 8'hA5

// Largest write payload in bytes, 16 beats of 32 bits
`define FP_MAX_PAYLOAD 64

// Default link rates
`define FP_CLK_FREQ_HZ 125_000_000
`define FP_BAUD_RATE 115200

// Idle limit inside a frame, in UART byte times
`define FP_TIMEOUT_BYTE_TIMES 10

// One byte time is ten bit times (start, 8 data, stop)
`define FP_TIMEOUT_CLOCKS \
    ((`FP_CLK_FREQ_HZ / (`FP_BAUD_RATE / 10)) * `FP_TIMEOUT_BYTE_TIMES)

`endif

// File: hdl/uart_frame_pkg.sv
package uart_frame_pkg;

    // Transfer size of one beat
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_RSVD = 2'd3    // Reserved, rejected as invalid command
    } size_code_t;

    // Command byte, bit 7 down to bit 0
    typedef struct packed {
        logic       rw;     // 1 = read
        logic       inc;    // Address increment between beats
        size_code_t size;
        logic [3:0] len;    // Beats minus one
    } cmd_fields_t;

    // Fields ahead of the payload
    typedef struct packed {
        cmd_fields_t cmd;
        logic [31:0] addr;
    } frame_hdr_t;

    // Result code of a parsed frame
    typedef enum logic [7:0] {
        STATUS_OK      = 8'h00,
        STATUS_CRC_ERR = 8'h01,
        STATUS_CMD_INV = 8'h02,
        STATUS_TIMEOUT = 8'h04
    } frame_status_t;

    // CRC-8 generator, x^8 + x^2 + x + 1
    localparam logic [7:0] CRC8_POLY = 8'h07;

endpackage

// File: hdl/frame_parser_pkg.sv
`include "frame_parser_settings.svh"

package frame_parser_pkg;

    // Width of a payload byte index
    localparam int PAYLOAD_IDX_W = $clog2(`FP_MAX_PAYLOAD);

    typedef enum logic [3:0] {
        ST_IDLE,        // Hunting for start byte
        ST_CMD,
        ST_ADDR0,
        ST_ADDR1,
        ST_ADDR2,
        ST_ADDR3,
        ST_DATA,        // Write payload
        ST_CRC,
        ST_VALIDATE,    // Result held for the consumer
        ST_ERROR        // Frame aborted on idle timeout
    } parser_state_t;

    // One payload byte as it leaves the parser
    typedef struct packed {
        logic [7:0]               data;
        logic [PAYLOAD_IDX_W-1:0] index;
    } payload_beat_t;

endpackage

// File: hdl/crc8_engine.sv
module crc8_engine (
    input  logic       clk,
    input  logic       rst,
    input  logic       crc_clear,
    input  logic       crc_enable,
    input  logic [7:0] data,
    output logic [7:0] crc_value
);
    import uart_frame_pkg::*;

    logic [7:0] crc_next;

    // Whole byte folded in per cycle, MSB first
    always_comb begin
        crc_next = crc_value ^ data;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) begin
                crc_next = {crc_next[6:0], 1'b0} ^ CRC8_POLY;
            end else begin
                crc_next = {crc_next[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc_value <= 8'h00;     // Initial value zero
        end else if (crc_enable) begin
            crc_value <= crc_next;
        end
    end

endmodule

// File: hdl/idle_timeout_counter.sv
`include "frame_parser_settings.svh"

module idle_timeout_counter #(
    parameter int timeout_clocks = `FP_TIMEOUT_CLOCKS
) (
    input  logic clk,
    input  logic rst,
    input  logic mid_frame,
    input  logic byte_taken,
    output logic timed_out
);

    localparam int cnt_w = $clog2(timeout_clocks + 1);
    localparam logic [cnt_w-1:0] limit = cnt_w'(timeout_clocks);

    logic [cnt_w-1:0] idle_count;

    // Counts only stalls inside a frame
    always_ff @(posedge clk) begin
        if (rst) begin
            idle_count <= '0;
        end else if (!mid_frame || byte_taken) begin
            idle_count <= '0;
        end else if (idle_count != limit) begin
            idle_count <= idle_count + 1'b1;   // Saturates at the limit
        end
    end

    // High once the stall has lasted the full limit
    assign timed_out = (idle_count == limit);

endmodule

// File: hdl/frame_parser_fsm.sv
`include "frame_parser_settings.svh"

module frame_parser_fsm (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [7:0]                     rx_fifo_data,
    input  logic                           rx_fifo_empty,
    output logic                           rx_fifo_rd_en,
    input  logic [7:0]                     crc_value,
    input  logic                           timed_out,
    output logic                           crc_clear,
    output logic                           crc_enable,
    output logic                           mid_frame,
    output uart_frame_pkg::frame_hdr_t     hdr,
    output frame_parser_pkg::payload_beat_t payload,
    output logic                           payload_valid,
    input  logic                           frame_consumed,
    output logic                           frame_valid,
    output logic                           frame_error,
    output uart_frame_pkg::frame_status_t  status,
    output logic                           busy
);
    import uart_frame_pkg::*;
    import frame_parser_pkg::*;

    parser_state_t state, state_next;

    logic [PAYLOAD_IDX_W-1:0] data_count;   // Index of the next payload byte
    logic [PAYLOAD_IDX_W:0]   exp_len;      // 0 to 64 bytes
    logic [PAYLOAD_IDX_W:0]   beats;
    logic                     last_beat;
    logic                     timeout_abort;

    // Expected payload from the captured command
    always_comb begin
        beats = (PAYLOAD_IDX_W + 1)'(hdr.cmd.len) + 1'b1;
        if (hdr.cmd.rw) begin
            exp_len = '0;
        end else begin
            case (hdr.cmd.size)
                SIZE_BYTE: exp_len = beats;
                SIZE_HALF: exp_len = beats << 1;
                SIZE_WORD: exp_len = beats << 2;
                default:   exp_len = '0;
            endcase
        end
    end

    assign last_beat = ({1'b0, data_count} == exp_len - 1'b1);

    assign mid_frame = (state inside {ST_CMD, ST_ADDR0, ST_ADDR1, ST_ADDR2,
                                      ST_ADDR3, ST_DATA, ST_CRC});

    // Pop whenever a byte is there, except while a result is held
    assign rx_fifo_rd_en = !rx_fifo_empty && (state == ST_IDLE || mid_frame);
    assign crc_clear = (state == ST_IDLE) && rx_fifo_rd_en && (rx_fifo_data == `FP_SOF_BYTE);
    assign crc_enable = rx_fifo_rd_en && mid_frame && (state != ST_CRC);
    assign timeout_abort = mid_frame && rx_fifo_empty && timed_out;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:  if (crc_clear) state_next = ST_CMD;
            ST_CMD:   if (rx_fifo_rd_en) state_next = ST_ADDR0;
            ST_ADDR0: if (rx_fifo_rd_en) state_next = ST_ADDR1;
            ST_ADDR1: if (rx_fifo_rd_en) state_next = ST_ADDR2;
            ST_ADDR2: if (rx_fifo_rd_en) state_next = ST_ADDR3;
            ST_ADDR3: begin
                if (rx_fifo_rd_en) begin
                    state_next = (exp_len == '0) ? ST_CRC : ST_DATA;
                end
            end
            ST_DATA:  if (rx_fifo_rd_en && last_beat) state_next = ST_CRC;
            ST_CRC:   if (rx_fifo_rd_en) state_next = ST_VALIDATE;
            ST_VALIDATE, ST_ERROR: begin
                if (frame_consumed) state_next = ST_IDLE;
            end
            default:  state_next = ST_IDLE;
        endcase
        if (timeout_abort) begin
            state_next = ST_ERROR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            status <= STATUS_OK;
            payload_valid <= 1'b0;
        end else begin
            state <= state_next;
            payload_valid <= (state == ST_DATA) && rx_fifo_rd_en;
            if (crc_clear) begin
                status <= STATUS_OK;    // New frame starts clean
            end else if (timeout_abort) begin
                status <= STATUS_TIMEOUT;
            end else if (state == ST_CRC && rx_fifo_rd_en) begin
                if (hdr.cmd.size == SIZE_RSVD) begin
                    status <= STATUS_CMD_INV;
                end else if (rx_fifo_data != crc_value) begin
                    status <= STATUS_CRC_ERR;
                end else begin
                    status <= STATUS_OK;
                end
            end
        end
    end

    // Field capture and payload beat
    always_ff @(posedge clk) begin
        if (rx_fifo_rd_en) begin
            case (state)
                ST_CMD:   hdr.cmd <= cmd_fields_t'(rx_fifo_data);
                ST_ADDR0: hdr.addr[7:0] <= rx_fifo_data;
                ST_ADDR1: hdr.addr[15:8] <= rx_fifo_data;
                ST_ADDR2: hdr.addr[23:16] <= rx_fifo_data;
                ST_ADDR3: begin
                    hdr.addr[31:24] <= rx_fifo_data;
                    data_count <= '0;
                end
                ST_DATA: begin
                    payload.data <= rx_fifo_data;
                    payload.index <= data_count;
                    data_count <= data_count + 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign frame_valid = (state == ST_VALIDATE) && (status == STATUS_OK);
    assign frame_error = ((state == ST_VALIDATE) && (status != STATUS_OK)) || (state == ST_ERROR);
    assign busy = (state != ST_IDLE);

endmodule

// File: hdl/frame_parser_top.sv
`include "frame_parser_settings.svh"

module frame_parser_top #(
    parameter int timeout_clocks = `FP_TIMEOUT_CLOCKS
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [7:0]                      rx_fifo_data,
    input  logic                            rx_fifo_empty,
    output logic                            rx_fifo_rd_en,
    output uart_frame_pkg::frame_hdr_t      hdr,
    output frame_parser_pkg::payload_beat_t payload,
    output logic                            payload_valid,
    input  logic                            frame_consumed,
    output logic                            frame_valid,
    output logic                            frame_error,
    output uart_frame_pkg::frame_status_t   status,
    output logic                            busy
);

    logic [7:0] crc_value;
    logic       crc_clear;
    logic       crc_enable;
    logic       mid_frame;
    logic       timed_out;

    frame_parser_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .crc_value      (crc_value),
        .timed_out      (timed_out),
        .crc_clear      (crc_clear),
        .crc_enable     (crc_enable),
        .mid_frame      (mid_frame),
        .hdr            (hdr),
        .payload        (payload),
        .payload_valid  (payload_valid),
        .frame_consumed (frame_consumed),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .status         (status),
        .busy           (busy)
    );

    // CRC sees the FIFO head directly, enable marks the popped bytes
    crc8_engine u_crc (
        .clk        (clk),
        .rst        (rst),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .data       (rx_fifo_data),
        .crc_value  (crc_value)
    );

    idle_timeout_counter #(
        .timeout_clocks (timeout_clocks)
    ) u_timeout (
        .clk        (clk),
        .rst        (rst),
        .mid_frame  (mid_frame),
        .byte_taken (rx_fifo_rd_en),    // Every pop counts as activity
        .timed_out  (timed_out)
    );

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #10 rst = 1'b0;     // Released off the edge like the other inputs
    end

endmodule

// File: tests/frame_parser_tb.sv
`include "frame_parser_settings.svh"

module frame_parser_tb;
    import uart_frame_pkg::*;
    import frame_parser_pkg::*;

    localparam int MAX_WAIT = 400;     // Cycles, longest frame plus the idle limit

    typedef struct packed {
        logic [3:0]    garbage;         // Noise bytes ahead of the start byte
        logic [7:0]    cmd;
        logic [31:0]   addr;
        logic          bad_crc;
        logic          truncate;        // Frame ends after the address bytes
        frame_status_t exp_status;
    } test_row_t;

    logic          clk;
    logic          rst;
    logic [7:0]    rx_fifo_data;
    logic          rx_fifo_empty;
    logic          rx_fifo_rd_en;
    frame_hdr_t    hdr;
    payload_beat_t payload;
    logic          payload_valid;
    logic          frame_consumed;
    logic          frame_valid;
    logic          frame_error;
    frame_status_t status;
    logic          busy;

    test_row_t                rows [$];
    string                    names [$];
    logic [7:0]               fifo_q [$];     // Receive FIFO model, head at index 0
    logic [7:0]               exp_data [$];
    logic [7:0]               got_data [$];
    logic [PAYLOAD_IDX_W-1:0] got_index [$];
    integer                   seed;

    tb_clock_gen #(.period(100), .reset_cycles(4)) u_clk_gen (.clk(clk), .rst(rst));

    frame_parser_top #(.timeout_clocks(40)) UUT (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .hdr            (hdr),
        .payload        (payload),
        .payload_valid  (payload_valid),
        .frame_consumed (frame_consumed),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .status         (status),
        .busy           (busy)
    );

    // CRC-8, polynomial 0x07, one bit at a time MSB first
    function automatic logic [7:0] crc8_step(input logic [7:0] crc, input logic [7:0] b);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ b[i];
            c = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ 8'h07;
            end
        end
        return c;
    endfunction

    // Reads and reserved sizes carry no payload
    function automatic int payload_len(input logic [7:0] cmd);
        int n;
        if (cmd[7] || cmd[5:4] == 2'd3) begin
            n = 0;
        end else begin
            n = (int'(cmd[3:0]) + 1) << cmd[5:4];
        end
        return n;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h, actual %0h", test, what, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("tests failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic present_head();
        rx_fifo_empty = (fifo_q.size() == 0);
        rx_fifo_data = rx_fifo_empty ? 8'h00 : fifo_q[0];
    endtask

    // One clock: sample at the falling edge, drive 10 units after the rising edge
    task automatic tick();
        logic       popped;
        logic [7:0] dropped;
        @(negedge clk);
        popped = rx_fifo_rd_en;
        if (payload_valid) begin
            got_data.push_back(payload.data);
            got_index.push_back(payload.index);
        end
        @(posedge clk);
        #10;
        if (popped && fifo_q.size() > 0) begin
            dropped = fifo_q.pop_front();
        end
        present_head();
    endtask

    task automatic add_row(input string name, input logic [3:0] garbage, input logic [7:0] cmd,
                           input logic [31:0] addr, input logic bad_crc, input logic truncate,
                           input frame_status_t exp_status);
        names.push_back(name);
        rows.push_back('{garbage, cmd, addr, bad_crc, truncate, exp_status});
    endtask

    task automatic run_row(input int t);
        test_row_t   row;
        logic [7:0]  crc;
        logic [7:0]  b;
        logic [31:0] rnd;
        int          cycles;
        row = rows[t];
        crc = 8'h00;
        exp_data.delete();
        got_data.delete();
        got_index.delete();
        for (int i = 0; i < row.garbage; i++) begin
            rnd = $random(seed);
            b = (rnd[7:0] == `FP_SOF_BYTE) ? 8'h5A : rnd[7:0];  // Noise must not look like SOF
            fifo_q.push_back(b);
        end
        fifo_q.push_back(`FP_SOF_BYTE);
        fifo_q.push_back(row.cmd);
        crc = crc8_step(crc, row.cmd);
        for (int i = 0; i < 4; i++) begin
            b = row.addr[8*i +: 8];     // LSB first
            fifo_q.push_back(b);
            crc = crc8_step(crc, b);
        end
        if (!row.truncate) begin
            for (int i = 0; i < payload_len(row.cmd); i++) begin
                rnd = $random(seed);
                exp_data.push_back(rnd[7:0]);
                fifo_q.push_back(rnd[7:0]);
                crc = crc8_step(crc, rnd[7:0]);
            end
            fifo_q.push_back(row.bad_crc ? ~crc : crc);
        end
        present_head();

        cycles = 0;
        while (!(frame_valid || frame_error) && cycles < MAX_WAIT) begin
            tick();
            cycles++;
        end
        if (!(frame_valid || frame_error)) begin
            report_timeout({"frame_valid or frame_error in test ", names[t]});
        end

        check_value(names[t], "frame_valid", 32'(row.exp_status == STATUS_OK), 32'(frame_valid));
        check_value(names[t], "frame_error", 32'(row.exp_status != STATUS_OK), 32'(frame_error));
        check_value(names[t], "status", 32'(row.exp_status), 32'(status));
        check_value(names[t], "busy while held", 32'(1), 32'(busy));
        check_value(names[t], "hdr.cmd", 32'(row.cmd), 32'(hdr.cmd));
        check_value(names[t], "hdr.addr", row.addr, hdr.addr);
        check_value(names[t], "payload count", 32'(exp_data.size()), 32'(got_data.size()));
        foreach (got_data[i]) begin
            check_value(names[t], "payload data", 32'(exp_data[i]), 32'(got_data[i]));
            check_value(names[t], "payload index", 32'(i), 32'(got_index[i]));
        end

        frame_consumed = 1'b1;
        tick();
        frame_consumed = 1'b0;
        check_value(names[t], "frame_valid after consume", 32'(0), 32'(frame_valid));
        check_value(names[t], "frame_error after consume", 32'(0), 32'(frame_error));
        check_value(names[t], "busy after consume", 32'(0), 32'(busy));
    endtask

    initial begin
        int cycles;
        seed = 48788;
        rx_fifo_data = 8'h00;
        rx_fifo_empty = 1'b1;
        frame_consumed = 1'b0;

        // Name, garbage, cmd {rw, inc, size, len}, addr, bad CRC, truncate, expected status
        add_row("wr_byte",      4'd3, 8'h45, 32'h1000_0040, 1'b0, 1'b0, STATUS_OK);
        add_row("wr_half",      4'd1, 8'h53, 32'h2000_0102, 1'b0, 1'b0, STATUS_OK);
        add_row("wr_word_max",  4'd2, 8'h2F, 32'hDEAD_BEEF, 1'b0, 1'b0, STATUS_OK);
        add_row("rd_word",      4'd0, 8'hE3, 32'h4000_0010, 1'b0, 1'b0, STATUS_OK);
        add_row("crc_bad",      4'd1, 8'h11, 32'h0000_0ABC, 1'b1, 1'b0, STATUS_CRC_ERR);
        add_row("size_rsvd",    4'd0, 8'h32, 32'h5555_AAAA, 1'b0, 1'b0, STATUS_CMD_INV);
        add_row("truncated",    4'd2, 8'h60, 32'h0BAD_F00D, 1'b0, 1'b1, STATUS_TIMEOUT);
        add_row("wr_after_err", 4'd0, 8'h40, 32'h1234_5678, 1'b0, 1'b0, STATUS_OK);

        cycles = 0;
        while (rst && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (rst) begin
            report_timeout("reset release");
        end
        tick();

        check_value("reset", "frame_valid", 32'(0), 32'(frame_valid));
        check_value("reset", "frame_error", 32'(0), 32'(frame_error));
        check_value("reset", "busy", 32'(0), 32'(busy));
        check_value("reset", "payload_valid", 32'(0), 32'(payload_valid));
        check_value("reset", "rx_fifo_rd_en", 32'(0), 32'(rx_fifo_rd_en));
        check_value("reset", "status", 32'(STATUS_OK), 32'(status));

        for (int t = 0; t < rows.size(); t++) begin
            run_row(t);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/uart_frame_pkg.sv
hdl/frame_parser_pkg.sv
hdl/crc8_engine.sv
hdl/idle_timeout_counter.sv
hdl/frame_parser_fsm.sv
hdl/frame_parser_top.sv
tests/tb_clock_gen.sv
tests/frame_parser_tb.sv

// File: Bender.yml
package:
  name: frame_parser

sources:
  - include_dirs:
      - include
    files:
      - hdl/uart_frame_pkg.sv
      - hdl/frame_parser_pkg.sv
      - hdl/crc8_engine.sv
      - hdl/idle_timeout_counter.sv
      - hdl/frame_parser_fsm.sv
      - hdl/frame_parser_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/frame_parser_tb.sv
